/* compile.f */
source/core_pkg.sv
source/alu.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/load_store_unit.sv
source/riscv_core_top.sv
tb/core_chk.sv
tb/tb_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the core testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_core -o sim_core

# a stopped simulation still leaves its output for the search below
out="$(./obj_dir/sim_core 2>&1 || true)"
echo "$out"

if grep -qx "TEST PASS" <<< "$out"; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1

/* source/alu.sv */
////////////////////////////////////////////////////////////////////////////
// integer alu
// add, sub, and, or, xor, signed slt and the operand compare for beq
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu
(
  input  core_pkg::alu_req_t         req_i,
  output logic [core_pkg::XLEN-1:0]  result_o,
  output logic                       equal_o
);

  always_comb
  begin
    case (req_i.op)
      core_pkg::ALU_ADD: result_o = req_i.operand_a + req_i.operand_b;
      core_pkg::ALU_SUB: result_o = req_i.operand_a - req_i.operand_b;
      core_pkg::ALU_AND: result_o = req_i.operand_a & req_i.operand_b;
      core_pkg::ALU_OR:  result_o = req_i.operand_a | req_i.operand_b;
      core_pkg::ALU_XOR: result_o = req_i.operand_a ^ req_i.operand_b;
      core_pkg::ALU_SLT:
      begin
        // 0 or 1, two's complement compare
        result_o = {31'b0, $signed(req_i.operand_a) < $signed(req_i.operand_b)};
      end
      default: result_o = '0;
    endcase
  end

  assign equal_o = (req_i.operand_a == req_i.operand_b); // beq decision

endmodule

/* source/core_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared definitions of the rv32i subset core
// data and register index widths, boot address
// kept major opcodes and alu operations
// packed structs for fetch, alu, data port and writeback
////////////////////////////////////////////////////////////////////////////

package core_pkg;

  localparam int unsigned XLEN       = 32; // data and address width
  localparam int unsigned REG_ADDR_W = 5;  // 32 registers

  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0080; // first fetch address

  // major opcodes the core executes
  // everything else decodes as a no-op and retires
  typedef enum logic [6:0]
  {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0]
  {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT  // signed compare
  } alu_op_e;

  // fetched word plus its address
  typedef struct packed
  {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
  } fetch_pkt_t;

  typedef struct packed
  {
    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } alu_req_t;

  // decode -> lsu, and the data port itself
  typedef struct packed
  {
    logic            we;    // 1 for stores
    logic [3:0]      be;    // byte enables
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

  // register file write port
  typedef struct packed
  {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } wb_t;

endpackage

/* source/decode_stage.sv */
////////////////////////////////////////////////////////////////////////////
// decode and execute
// opcode and alu decode, immediates, operand read, beq resolution,
// dispatch of lw/sw/sb to the lsu, register writeback mux
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_stage
(
  input  logic                            clk,
  input  logic                            rst_ni,
  input  logic                            fetch_valid_i,
  input  core_pkg::fetch_pkt_t            fetch_pkt_i,
  output logic                            id_ready_o,
  output logic                            redirect_o,
  output logic [core_pkg::XLEN-1:0]       redirect_pc_o,
  input  logic                            lsu_ready_i,
  output logic                            lsu_valid_o,
  output core_pkg::mem_req_t              lsu_req_o,
  output logic [core_pkg::REG_ADDR_W-1:0] lsu_rd_o,
  input  core_pkg::wb_t                   load_wb_i,
  output logic                            retire_o
);

  logic [core_pkg::XLEN-1:0]  instr;
  core_pkg::opcode_e          opcode;
  logic [2:0]                 funct3;
  logic [core_pkg::XLEN-1:0]  imm_i, imm_s, imm_b;
  logic [core_pkg::XLEN-1:0]  rs1_data, rs2_data;
  core_pkg::alu_op_e          reg_op;   // from funct3/funct7
  logic                       op_ok;
  logic                       is_alu, is_load, is_store, is_beq;
  logic                       accept;
  core_pkg::alu_req_t         alu_req;
  logic [core_pkg::XLEN-1:0]  alu_result;
  logic                       alu_equal;
  core_pkg::wb_t              alu_wb, rf_wb;

  assign instr  = fetch_pkt_i.instr;
  assign opcode = core_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // alu operation decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    op_ok  = 1'b1;
    reg_op = core_pkg::ALU_ADD;
    case (funct3)
      3'b000: if (opcode == core_pkg::OPC_OP && instr[30]) reg_op = core_pkg::ALU_SUB;
      3'b010: reg_op = core_pkg::ALU_SLT;
      3'b100: reg_op = core_pkg::ALU_XOR;
      3'b110: reg_op = core_pkg::ALU_OR;
      3'b111: reg_op = core_pkg::ALU_AND;
      default: op_ok = 1'b0;                 // shifts, sltu
    endcase
    if (opcode == core_pkg::OPC_OP && (instr[31] || instr[29:25] != '0))
      op_ok = 1'b0;                          // mul and friends
  end

  assign is_alu   = (opcode == core_pkg::OPC_OP || opcode == core_pkg::OPC_OP_IMM) && op_ok;
  assign is_load  = (opcode == core_pkg::OPC_LOAD) && (funct3 == 3'b010);   // lw only
  assign is_store = (opcode == core_pkg::OPC_STORE) && (funct3 == 3'b000 || funct3 == 3'b010);
  assign is_beq   = (opcode == core_pkg::OPC_BRANCH) && (funct3 == 3'b000);

  // operand select, address adds go through the alu as well
  always_comb
  begin
    alu_req.op        = is_alu ? reg_op : core_pkg::ALU_ADD;
    alu_req.operand_a = rs1_data;
    if (opcode == core_pkg::OPC_OP || is_beq)
      alu_req.operand_b = rs2_data;
    else if (opcode == core_pkg::OPC_STORE)
      alu_req.operand_b = imm_s;
    else
      alu_req.operand_b = imm_i;
  end

  // whole core waits while the lsu is busy, load result owns the write port
  assign id_ready_o = lsu_ready_i && !load_wb_i.we;
  assign accept     = fetch_valid_i && id_ready_o;

  assign redirect_o    = accept && is_beq && alu_equal;
  assign redirect_pc_o = fetch_pkt_i.pc + imm_b;

  assign lsu_valid_o     = fetch_valid_i && (is_load || is_store) && !load_wb_i.we;
  assign lsu_req_o.we    = is_store;
  assign lsu_req_o.be    = (is_store && funct3 == 3'b000) ? 4'b0001 : 4'b1111; // sb: lane 0
  assign lsu_req_o.addr  = alu_result;
  assign lsu_req_o.wdata = rs2_data;
  assign lsu_rd_o        = instr[11:7];

  assign retire_o = accept && !is_store;   // stores count on their grant

  assign alu_wb.we    = accept && is_alu;
  assign alu_wb.waddr = instr[11:7];
  assign alu_wb.wdata = alu_result;
  assign rf_wb        = load_wb_i.we ? load_wb_i : alu_wb;

  register_file u_register_file
  (
    .clk       ( clk           ),
    .rst_ni    ( rst_ni        ),
    .raddr_a_i ( instr[19:15]  ),
    .raddr_b_i ( instr[24:20]  ),
    .rdata_a_o ( rs1_data      ),
    .rdata_b_o ( rs2_data      ),
    .wb_i      ( rf_wb         )
  );

  alu u_alu
  (
    .req_i    ( alu_req    ),
    .result_o ( alu_result ),
    .equal_o  ( alu_equal  )
  );

endmodule

/* source/fetch_stage.sv */
////////////////////////////////////////////////////////////////////////////
// instruction fetch
// pc register, three-state request fsm on the req/gnt/rvalid port,
// one-entry fetched-instruction buffer towards decode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_stage
(
  input  logic                       clk,
  input  logic                       rst_ni,
  // instruction memory port
  output logic                       instr_req_o,
  output logic [core_pkg::XLEN-1:0]  instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]  instr_rdata_i,
  // to decode
  output logic                       fetch_valid_o,
  output core_pkg::fetch_pkt_t       fetch_pkt_o,
  input  logic                       id_ready_i,
  // taken branch from decode
  input  logic                       redirect_i,
  input  logic [core_pkg::XLEN-1:0]  redirect_pc_i
);

  typedef enum logic [1:0] {F_IDLE, F_WAIT_GNT, F_WAIT_RVALID} fetch_state_e;

  fetch_state_e               state_q;
  logic [core_pkg::XLEN-1:0]  pc_q;    // next address to fetch
  logic [core_pkg::XLEN-1:0]  addr_q;  // address of the open request
  logic                       valid_q;
  core_pkg::fetch_pkt_t       pkt_q;
  logic                       issue;

  // buffer empty or draining this cycle, and no branch being taken
  // so a taken branch never leaves a wrong-path request in flight
  assign issue = (state_q == F_IDLE) && (!valid_q || id_ready_i) && !redirect_i;

  always_ff @(posedge clk)
  begin
    if (!rst_ni)
    begin
      state_q <= F_IDLE;
      pc_q    <= core_pkg::BOOT_ADDR;
      valid_q <= 1'b0;
    end
    else
    begin
      if (valid_q && id_ready_i)
        valid_q <= 1'b0;                      // consumed by decode
      if (redirect_i)
      begin
        pc_q    <= redirect_pc_i;
        valid_q <= 1'b0;
      end
      case (state_q)
        F_IDLE:
          if (issue)
          begin
            state_q <= F_WAIT_GNT;
            pc_q    <= pc_q + 32'd4;
          end
        F_WAIT_GNT:
          if (instr_gnt_i)
            state_q <= F_WAIT_RVALID;
        F_WAIT_RVALID:
          if (instr_rvalid_i)
          begin
            state_q <= F_IDLE;
            valid_q <= 1'b1;
          end
        default: state_q <= F_IDLE;
      endcase
    end
  end

  // address and fetched word
  always_ff @(posedge clk)
  begin
    if (issue)
      addr_q <= pc_q;
    if (state_q == F_WAIT_RVALID && instr_rvalid_i)
    begin
      pkt_q.instr <= instr_rdata_i;
      pkt_q.pc    <= addr_q;
    end
  end

  assign instr_req_o   = (state_q == F_WAIT_GNT); // held until the grant cycle
  assign instr_addr_o  = addr_q;
  assign fetch_valid_o = valid_q;
  assign fetch_pkt_o   = pkt_q;

endmodule

/* source/load_store_unit.sv */
////////////////////////////////////////////////////////////////////////////
// load store unit
// data port fsm, sb byte enables and lane replication,
// lw writeback and store completion
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module load_store_unit
(
  input  logic                            clk,
  input  logic                            rst_ni,
  // from decode
  input  logic                            lsu_valid_i,
  input  core_pkg::mem_req_t              lsu_req_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] load_rd_i,
  output logic                            lsu_ready_o,
  // data memory port
  output logic                            data_req_o,
  output core_pkg::mem_req_t              data_o,
  input  logic                            data_gnt_i,
  input  logic                            data_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]       data_rdata_i,
  // results
  output core_pkg::wb_t                   load_wb_o,
  output logic                            store_done_o
);

  typedef enum logic [1:0] {L_IDLE, L_WAIT_GNT, L_WAIT_RVALID} lsu_state_e;

  lsu_state_e                       state_q;
  core_pkg::mem_req_t               req_q;
  logic [core_pkg::REG_ADDR_W-1:0]  rd_q;
  logic                             resp;
  logic                             accept;

  assign resp        = (state_q == L_WAIT_RVALID) && data_rvalid_i;
  assign lsu_ready_o = (state_q == L_IDLE) || resp;   // free again on the response
  assign accept      = lsu_valid_i && lsu_ready_o;

  always_ff @(posedge clk)
  begin
    if (!rst_ni)
      state_q <= L_IDLE;
    else
    begin
      case (state_q)
        L_IDLE:
          if (accept)
            state_q <= L_WAIT_GNT;
        L_WAIT_GNT:
          if (data_gnt_i)
            state_q <= L_WAIT_RVALID;
        L_WAIT_RVALID:
          if (data_rvalid_i)
            state_q <= accept ? L_WAIT_GNT : L_IDLE;  // back to back
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // request payload, held stable until the grant
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_q.we   <= lsu_req_i.we;
      req_q.be   <= lsu_req_i.be << lsu_req_i.addr[1:0];  // sb lane from addr
      req_q.addr <= lsu_req_i.addr;
      if (lsu_req_i.be == 4'b0001)
        req_q.wdata <= {4{lsu_req_i.wdata[7:0]}};         // byte on every lane
      else
        req_q.wdata <= lsu_req_i.wdata;
      rd_q <= load_rd_i;
    end
  end

  assign data_req_o = (state_q == L_WAIT_GNT);
  assign data_o     = req_q;

  assign store_done_o = data_req_o && data_gnt_i && req_q.we;

  // lw returns the full word
  assign load_wb_o.we    = resp && !req_q.we;
  assign load_wb_o.waddr = rd_q;
  assign load_wb_o.wdata = data_rdata_i;

endmodule

/* source/register_file.sv */
////////////////////////////////////////////////////////////////////////////
// integer register file
// 31 registers plus x0, two combinational read ports, one write port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module register_file
(
  input  logic                            clk,
  input  logic                            rst_ni,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [core_pkg::XLEN-1:0]       rdata_b_o,
  input  core_pkg::wb_t                   wb_i
);

  logic [core_pkg::XLEN-1:0] regs_q [1:31]; // no storage for x0

  always_ff @(posedge clk)
  begin
    if (!rst_ni)
    begin
      for (int i = 1; i < 32; i++)
        regs_q[i] <= '0;
    end
    else if (wb_i.we && wb_i.waddr != '0)
      regs_q[wb_i.waddr] <= wb_i.wdata;     // writes to x0 dropped
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* source/riscv_core_top.sv */
////////////////////////////////////////////////////////////////////////////
// top level of the rv32i subset core
// fetch, decode and lsu instances, stage wiring,
// retired-instruction and data-response tracing counters
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module riscv_core_top
(
  input  logic                       clk,
  input  logic                       rst_ni,
  // instruction memory
  output logic                       instr_req_o,
  output logic [core_pkg::XLEN-1:0]  instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]  instr_rdata_i,
  // data memory
  output logic                       data_req_o,
  output core_pkg::mem_req_t         data_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]  data_rdata_i,
  // tracing
  output logic [31:0]                instr_count_o,
  output logic [31:0]                mem_req_count_o
);

  logic                             fetch_valid;
  core_pkg::fetch_pkt_t             fetch_pkt;
  logic                             id_ready;
  logic                             redirect;
  logic [core_pkg::XLEN-1:0]        redirect_pc;
  logic                             lsu_valid, lsu_ready;
  core_pkg::mem_req_t               lsu_req;
  logic [core_pkg::REG_ADDR_W-1:0]  lsu_rd;
  core_pkg::wb_t                    load_wb;
  logic                             retire, store_done;

  fetch_stage u_fetch_stage
  (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fetch_valid_o  ( fetch_valid    ),
    .fetch_pkt_o    ( fetch_pkt      ),
    .id_ready_i     ( id_ready       ),
    .redirect_i     ( redirect       ),
    .redirect_pc_i  ( redirect_pc    )
  );

  decode_stage u_decode_stage
  (
    .clk           ( clk         ),
    .rst_ni        ( rst_ni      ),
    .fetch_valid_i ( fetch_valid ),
    .fetch_pkt_i   ( fetch_pkt   ),
    .id_ready_o    ( id_ready    ),
    .redirect_o    ( redirect    ),
    .redirect_pc_o ( redirect_pc ),
    .lsu_ready_i   ( lsu_ready   ),
    .lsu_valid_o   ( lsu_valid   ),
    .lsu_req_o     ( lsu_req     ),
    .lsu_rd_o      ( lsu_rd      ),
    .load_wb_i     ( load_wb     ), // has priority on the write port
    .retire_o      ( retire      )
  );

  load_store_unit u_load_store_unit
  (
    .clk           ( clk           ),
    .rst_ni        ( rst_ni        ),
    .lsu_valid_i   ( lsu_valid     ),
    .lsu_req_i     ( lsu_req       ),
    .load_rd_i     ( lsu_rd        ),
    .lsu_ready_o   ( lsu_ready     ),
    .data_req_o    ( data_req_o    ),
    .data_o        ( data_o        ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_rdata_i  ( data_rdata_i  ),
    .load_wb_o     ( load_wb       ),
    .store_done_o  ( store_done    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // tracing counters
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (!rst_ni)
    begin
      instr_count_o   <= '0;
      mem_req_count_o <= '0;
    end
    else
    begin
      // decode retires and store grants never coincide, summed anyway
      instr_count_o <= instr_count_o + 32'(retire) + 32'(store_done);
      if (data_rvalid_i)
        mem_req_count_o <= mem_req_count_o + 32'd1;  // every data response
    end
  end

endmodule

/* tb/core_chk.sv */
////////////////////////////////////////////////////////////////////////////
// protocol assertions on the core memory ports
// request hold until grant, rvalid only when outstanding,
// no request out of reset, bound into riscv_core_top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_chk
(
  input  logic                       clk,
  input  logic                       rst_ni,
  input  logic                       instr_req_i,
  input  logic [core_pkg::XLEN-1:0]  instr_addr_i,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic                       data_req_i,
  input  core_pkg::mem_req_t         data_i,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i
);

  logic instr_open_q;  // granted, response pending
  logic data_open_q;

  always_ff @(posedge clk)
  begin
    if (!rst_ni)
    begin
      instr_open_q <= 1'b0;
      data_open_q  <= 1'b0;
    end
    else
    begin
      if (instr_req_i && instr_gnt_i)
        instr_open_q <= 1'b1;
      else if (instr_rvalid_i)
        instr_open_q <= 1'b0;
      if (data_req_i && data_gnt_i)
        data_open_q <= 1'b1;
      else if (data_rvalid_i)
        data_open_q <= 1'b0;
    end
  end

  instr_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else $error("instruction request dropped or changed before its grant");

  data_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_i))
    else $error("data request dropped or changed before its grant");

  instr_resp: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_rvalid_i |-> instr_open_q)
    else $error("instruction rvalid with nothing outstanding");

  data_resp: assert property (@(posedge clk) disable iff (!rst_ni)
    data_rvalid_i |-> data_open_q)
    else $error("data rvalid with nothing outstanding");

  // state is reset one edge after rst_ni is seen low
  reset_quiet: assert property (@(posedge clk)
    !rst_ni |=> !instr_req_i && !data_req_i)
    else $error("memory request while in reset");

endmodule

bind riscv_core_top core_chk u_core_chk
(
  .clk            ( clk            ),
  .rst_ni         ( rst_ni         ),
  .instr_req_i    ( instr_req_o    ),
  .instr_addr_i   ( instr_addr_o   ),
  .instr_gnt_i    ( instr_gnt_i    ),
  .instr_rvalid_i ( instr_rvalid_i ),
  .data_req_i     ( data_req_o     ),
  .data_i         ( data_o         ),
  .data_gnt_i     ( data_gnt_i     ),
  .data_rvalid_i  ( data_rvalid_i  )
);

/* tb/tb_core.sv */
////////////////////////////////////////////////////////////////////////////
// testbench of the rv32i subset core
// clock and reset, random program, instruction and data memories
// with random grant delay, in-order reference model, checks, watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_core;

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 5;
  localparam int          N_INSTR      = 200;              // random part of the program
  localparam logic [31:0] DATA_BASE    = 32'h0000_0400;    // 64-word data window
  localparam logic [31:0] FINAL_PC     = core_pkg::BOOT_ADDR + 32'(4 * N_INSTR);

  logic                clk           = 1'b0;
  logic                rst_ni;
  logic                instr_req;
  logic [31:0]         instr_addr;
  logic                instr_gnt     = 1'b0;
  logic                instr_rvalid  = 1'b0;
  logic [31:0]         instr_rdata   = '0;
  logic                data_req;
  core_pkg::mem_req_t  data_bus;
  logic                data_gnt      = 1'b0;
  logic                data_rvalid   = 1'b0;
  logic [31:0]         data_rdata    = '0;
  logic [31:0]         instr_count;
  logic [31:0]         mem_req_count;

  integer              seed;
  logic [31:0]         imem [0:N_INSTR];  // program plus closing branch
  logic [31:0]         dmem [0:63];       // memory seen by the core
  logic [31:0]         mmem [0:63];       // model copy
  logic [31:0]         xr   [0:31];       // model registers
  logic [31:0]         exp_fetch_q [$];   // model pc trace
  core_pkg::mem_req_t  exp_data_q [$];    // model data operations
  core_pkg::mem_req_t  exp_op;
  logic [31:0]         exp_pc;
  logic [31:0]         word_idx;
  int                  exp_retired;
  int                  i_wait, d_wait;    // remaining grant delay
  int                  final_hits  = 0;
  int                  data_resps  = 0;
  int                  fetch_errs  = 0;
  int                  data_errs   = 0;
  int                  count_errs  = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  riscv_core_top DUT
  (
    .clk             ( clk           ),
    .rst_ni          ( rst_ni        ),
    .instr_req_o     ( instr_req     ),
    .instr_addr_o    ( instr_addr    ),
    .instr_gnt_i     ( instr_gnt     ),
    .instr_rvalid_i  ( instr_rvalid  ),
    .instr_rdata_i   ( instr_rdata   ),
    .data_req_o      ( data_req      ),
    .data_o          ( data_bus      ),
    .data_gnt_i      ( data_gnt      ),
    .data_rvalid_i   ( data_rvalid   ),
    .data_rdata_i    ( data_rdata    ),
    .instr_count_o   ( instr_count   ),
    .mem_req_count_o ( mem_req_count )
  );

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // add/sub, slt, xor, or, and
  function automatic logic [2:0] alu_f3(input int sel);
    case (sel)
      0:       return 3'b000;
      1:       return 3'b010;
      2:       return 3'b100;
      3:       return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] a;
    a = DATA_BASE + 32'(4 * idx);
    return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;  // every address bit counts
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] w;
    w = old_w;
    for (int j = 0; j < 4; j++)
      if (be[j])
        w[8*j +: 8] = new_w[8*j +: 8];
    return w;
  endfunction

  // rv32i integer ops, funct3 plus the sub bit
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // random program
  ////////////////////////////////////////////////////////////////////////////
  task automatic build_program();
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] off;
    int          kind;
    for (int i = 0; i < N_INSTR; i++)
    begin
      kind = rnd(8);
      rd   = 5'(1 + rnd(7));                       // x1..x7
      rs1  = 5'(rnd(8));
      rs2  = 5'(rnd(8));
      f3   = alu_f3(rnd(5));
      f7   = (f3 == 3'b000 && rnd(2) == 1) ? 7'b0100000 : 7'b0000000;
      off  = 12'(DATA_BASE + 32'(4 * rnd(64)));     // x0 based, inside the window
      if (kind == 7 && i == N_INSTR - 1)
        kind = 0;                                  // never skip the closing branch
      case (kind)
        0, 1: imem[i] = {12'(rnd(4096)), rs1, f3, rd, 7'b0010011};
        2, 3: imem[i] = {f7, rs2, rs1, f3, rd, 7'b0110011};
        4:    imem[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};   // sw
        5:
        begin
          off     = off + 12'(rnd(4));             // any byte lane
          imem[i] = {off[11:5], rs2, 5'd0, 3'b000, off[4:0], 7'b0100011};     // sb
        end
        6:    imem[i] = {off, 5'd0, 3'b010, rd, 7'b0000011};                  // lw
        default:
        begin
          if (rnd(2) == 0)
            rs2 = rs1;                             // taken for sure
          imem[i] = {7'b0, rs2, rs1, 3'b000, 5'b01000, 7'b1100011};           // beq +8
        end
      endcase
    end
    imem[N_INSTR] = 32'h0000_0063;                 // beq x0, x0, 0
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model, runs the program once up to the closing branch
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_model();
    logic [31:0]        w, a, b, imm_i, imm_s, imm_b;
    core_pkg::mem_req_t op;
    int                 pc;                        // word index
    pc          = 0;
    exp_retired = 0;
    for (int k = 0; k < 32; k++)
      xr[k] = '0;
    while (pc < N_INSTR)
    begin
      w     = imem[pc];
      a     = xr[w[19:15]];
      b     = xr[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      exp_fetch_q.push_back(core_pkg::BOOT_ADDR + 32'(4 * pc));  // first one is the boot pc
      exp_retired++;
      pc++;
      case (w[6:0])
        7'b0010011: xr[w[11:7]] = alu_ref(w[14:12], 1'b0, a, imm_i);
        7'b0110011: xr[w[11:7]] = alu_ref(w[14:12], w[30], a, b);
        7'b0000011:
        begin
          op          = '0;
          op.be       = 4'hf;
          op.addr     = a + imm_i;
          xr[w[11:7]] = mmem[op.addr[7:2]];
          exp_data_q.push_back(op);
        end
        7'b0100011:
        begin
          op.we    = 1'b1;
          op.addr  = a + imm_s;
          op.be    = (w[14:12] == 3'b000) ? 4'b0001 << op.addr[1:0] : 4'hf;
          op.wdata = (w[14:12] == 3'b000) ? {4{b[7:0]}} : b;
          mmem[op.addr[7:2]] = merge_bytes(mmem[op.addr[7:2]], op.wdata, op.be);
          exp_data_q.push_back(op);
        end
        default:
          if (a == b)
            pc = pc - 1 + int'($signed(imm_b)) / 4;     // beq
      endcase
      xr[0] = '0;
    end
    exp_fetch_q.push_back(FINAL_PC);
    exp_retired++;                                 // closing branch, first pass
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction memory, grant after 0..3 cycles, rvalid one cycle later
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    instr_gnt    <= 1'b0;
    instr_rvalid <= 1'b0;
    if (!rst_ni)
      i_wait = -1;
    else if (instr_gnt && instr_req)
    begin
      i_wait = -1;
      if (exp_fetch_q.size() > 0)
        exp_pc = exp_fetch_q.pop_front();
      else
        exp_pc = FINAL_PC;                         // looping on the closing branch
      assert (instr_addr == exp_pc)
      else
      begin
        fetch_errs++;
        $display("** Error %0t: fetch address %h, expected %h", $time, instr_addr, exp_pc);
      end
      if (instr_addr == FINAL_PC)
        final_hits <= final_hits + 1;
      word_idx     = (instr_addr - core_pkg::BOOT_ADDR) >> 2;
      instr_rdata  <= (word_idx <= N_INSTR) ? imem[word_idx[7:0]] : 32'h0000_0013;
      instr_rvalid <= 1'b1;
    end
    else if (instr_req)
    begin
      if (i_wait < 0)
        i_wait = rnd(4);
      if (i_wait == 0)
        instr_gnt <= 1'b1;
      else
        i_wait--;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data memory, checked against the model operation order
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk)
  begin
    data_gnt    <= 1'b0;
    data_rvalid <= 1'b0;
    if (!rst_ni)
      d_wait = -1;
    else if (data_gnt && data_req)
    begin
      d_wait = -1;
      assert (exp_data_q.size() > 0)
      else
      begin
        data_errs++;
        $display("data request at %0t with no operation left in the model", $time);
      end
      if (exp_data_q.size() > 0)
      begin
        exp_op = exp_data_q.pop_front();
        assert (data_bus.we == exp_op.we && data_bus.addr == exp_op.addr &&
                (!exp_op.we || (data_bus.be == exp_op.be && data_bus.wdata == exp_op.wdata)))
        else
        begin
          data_errs++;
          $display("** Error %0t: data request %h, expected %h", $time, data_bus, exp_op);
        end
      end
      if (data_bus.we)
        dmem[data_bus.addr[7:2]] = merge_bytes(dmem[data_bus.addr[7:2]], data_bus.wdata,
                                               data_bus.be);
      else
        data_rdata <= dmem[data_bus.addr[7:2]];
      data_rvalid <= 1'b1;
      data_resps++;
    end
    else if (data_req)
    begin
      if (d_wait < 0)
        d_wait = rnd(4);
      if (d_wait == 0)
        data_gnt <= 1'b1;
      else
        d_wait--;
    end
  end

  initial
  begin
    seed   = 32'h7780_306d;
    rst_ni = 1'b0;
    for (int k = 0; k < 64; k++)
    begin
      dmem[k] = fill_word(k);
      mmem[k] = fill_word(k);
    end
    build_program();
    run_model();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_ni <= 1'b1;
    // second fetch of the closing branch, its first pass has retired
    while (final_hits < 2)
      @(posedge clk);
    @(negedge clk);
    assert (instr_count == 32'(exp_retired))
    else
    begin
      count_errs++;
      $display("** Error %0t: instr_count_o %0d, expected %0d", $time, instr_count, exp_retired);
    end
    assert (mem_req_count == 32'(data_resps))
    else
    begin
      count_errs++;
      $display("** Error %0t: mem_req_count_o %0d, expected %0d", $time, mem_req_count,
               data_resps);
    end
    assert (exp_data_q.size() == 0)
    else
    begin
      data_errs++;
      $display("%0d model data operations never reached the data port", exp_data_q.size());
    end
    $display("errors: fetch %0d, data %0d, counters %0d", fetch_errs, data_errs, count_errs);
    if (fetch_errs + data_errs + count_errs == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // watchdog, 20 cycles per program instruction
  initial
  begin
    #(CLK_PERIOD * (RESET_CYCLES + N_INSTR * 20));
    $display("timeout: the program never reached its closing branch twice");
    $display("errors: fetch %0d, data %0d, counters %0d", fetch_errs, data_errs, count_errs);
    $display("TEST FAIL");
    $finish;
  end

endmodule
